//--- include/nc_bypass_settings.svh
`ifndef NC_BYPASS_SETTINGS_SVH
`define NC_BYPASS_SETTINGS_SVH

// Core side
`define NUM_PORTS   2
`define WORD_BYTES  4
`define CORE_ADDR_W 10
`define ID_W        4

// Memory line and cache geometry
`define LINE_WORDS  2
`define MEM_TAG_W   6
`define CACHE_LINES 8

// Derived widths
`define WORD_W      (`WORD_BYTES * 8)
`define LINE_BYTES  (`WORD_BYTES * `LINE_WORDS)
`define LINE_W      (`LINE_BYTES * 8)
`define PORT_SEL_W  ($clog2(`NUM_PORTS))
`define WSEL_W      ($clog2(`LINE_WORDS))
`define LINE_IDX_W  ($clog2(`CACHE_LINES))
`define MEM_ADDR_W  (`CORE_ADDR_W - `WSEL_W)

`endif

//--- design/nc_bypass_pkg.sv
`include "nc_bypass_settings.svh"

package nc_bypass_pkg;

    typedef struct packed {
        logic             nc;
        logic [`ID_W-1:0] id;
    } core_tag_t;

    // rw high for a write
    typedef struct packed {
        logic                    rw;
        logic [`CORE_ADDR_W-1:0] addr;
        logic [`WORD_BYTES-1:0]  byteen;
        logic [`WORD_W-1:0]      data;
        core_tag_t               tag;
    } core_req_t;

    typedef struct packed {
        logic [`WORD_W-1:0] data;
        core_tag_t          tag;
    } core_rsp_t;

    // Bypass payload is {port, word select, id}, cache payload is the line index
    typedef struct packed {
        logic                  nc;
        logic [`MEM_TAG_W-1:0] payload;
    } mem_tag_t;

    typedef struct packed {
        logic                   rw;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`LINE_BYTES-1:0] byteen;
        logic [`LINE_W-1:0]     data;
        mem_tag_t               tag;
    } mem_req_t;

    typedef struct packed {
        logic [`LINE_W-1:0] data;
        mem_tag_t           tag;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        MISS_WAIT,
        RESPOND
    } cache_state_e;

endpackage

//--- design/req_arbiter.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module req_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`NUM_PORTS-1:0]  requests,
    output logic [`NUM_PORTS-1:0]  grant_onehot,
    output logic [`PORT_SEL_W-1:0] grant_index,
    output logic                   grant_valid,
    input  logic                   unlock
);
    localparam int SEL_W = `PORT_SEL_W;

    logic                  locked;
    logic [`NUM_PORTS-1:0] lock_onehot;
    logic [SEL_W-1:0]      lock_index;
    logic [`NUM_PORTS-1:0] pick_onehot;
    logic [SEL_W-1:0]      pick_index;

    // Lowest-numbered requester wins
    always_comb begin
        pick_onehot = '0;
        pick_index  = '0;
        for (int i = `NUM_PORTS - 1; i >= 0; i--) begin
            if (requests[i]) begin
                pick_onehot    = '0;
                pick_onehot[i] = 1'b1;
                pick_index     = SEL_W'(i);
            end
        end
    end

    assign grant_onehot = locked ? lock_onehot : pick_onehot;
    assign grant_index  = locked ? lock_index : pick_index;
    assign grant_valid  = |(requests & grant_onehot);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked <= 1'b0;
        end else begin
            locked <= grant_valid && !unlock;
        end
    end

    // Held grant stays put until the winner transfers
    always_ff @(posedge clk) begin
        if (!locked) begin
            lock_onehot <= pick_onehot;
            lock_index  <= pick_index;
        end
    end

endmodule

//--- design/cache_bypass.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module cache_bypass (
    input  logic                                      clk,
    input  logic                                      rst_n,
    // Core side
    input  nc_bypass_pkg::core_req_t [`NUM_PORTS-1:0] core_req_in,
    input  logic [`NUM_PORTS-1:0]                     core_req_valid_in,
    output logic [`NUM_PORTS-1:0]                     core_req_ready_in,
    output nc_bypass_pkg::core_rsp_t [`NUM_PORTS-1:0] core_rsp_out,
    output logic [`NUM_PORTS-1:0]                     core_rsp_valid_out,
    input  logic [`NUM_PORTS-1:0]                     core_rsp_ready_out,
    // Cache side
    output nc_bypass_pkg::core_req_t [`NUM_PORTS-1:0] cache_req,
    output logic [`NUM_PORTS-1:0]                     cache_req_valid,
    input  logic [`NUM_PORTS-1:0]                     cache_req_ready,
    input  nc_bypass_pkg::core_rsp_t [`NUM_PORTS-1:0] cache_rsp,
    input  logic [`NUM_PORTS-1:0]                     cache_rsp_valid,
    output logic [`NUM_PORTS-1:0]                     cache_rsp_ready,
    input  nc_bypass_pkg::mem_req_t                   cache_mem_req,
    input  logic                                      cache_mem_req_valid,
    output logic                                      cache_mem_req_ready,
    output nc_bypass_pkg::mem_rsp_t                   cache_mem_rsp,
    output logic                                      cache_mem_rsp_valid,
    input  logic                                      cache_mem_rsp_ready,
    // Memory side
    output nc_bypass_pkg::mem_req_t                   mem_req,
    output logic                                      mem_req_valid,
    input  logic                                      mem_req_ready,
    input  nc_bypass_pkg::mem_rsp_t                   mem_rsp,
    input  logic                                      mem_rsp_valid,
    output logic                                      mem_rsp_ready
);
    import nc_bypass_pkg::*;

    localparam int SEL_W  = `PORT_SEL_W;
    localparam int WSEL_W = `WSEL_W;

    logic [`NUM_PORTS-1:0] req_nc;
    logic [`NUM_PORTS-1:0] nc_valid;
    logic [`NUM_PORTS-1:0] nc_onehot;
    logic [SEL_W-1:0]      nc_index;
    logic                  nc_grant;
    logic                  nc_drive;
    logic                  nc_ready;
    logic                  nc_hold;
    core_req_t             nc_sel;
    logic [WSEL_W-1:0]     nc_wsel;
    mem_req_t              nc_mem_req;
    logic                  rsp_nc;
    logic [SEL_W-1:0]      rsp_port;
    logic [WSEL_W-1:0]     rsp_wsel;
    logic [`ID_W-1:0]      rsp_id;
    logic [`WORD_W-1:0]    rsp_word;

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            req_nc[i]           = core_req_in[i].tag.nc;
            cache_req[i]        = core_req_in[i];
            cache_req[i].tag.nc = 1'b0;
        end
    end

    assign nc_valid        = core_req_valid_in & req_nc;
    assign cache_req_valid = core_req_valid_in & ~req_nc;

    req_arbiter nc_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .requests     (nc_valid),
        .grant_onehot (nc_onehot),
        .grant_index  (nc_index),
        .grant_valid  (nc_grant),
        .unlock       (nc_ready)
    );

    // Cache wins the bus, but a stalled bypass request keeps it until taken
    assign nc_drive = nc_grant && (nc_hold || !cache_mem_req_valid);
    assign nc_ready = nc_drive && mem_req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nc_hold <= 1'b0;
        end else begin
            nc_hold <= nc_drive && !mem_req_ready;
        end
    end

    assign core_req_ready_in = (req_nc & nc_onehot & {`NUM_PORTS{nc_ready}})
                             | (~req_nc & cache_req_ready);

    assign nc_sel  = core_req_in[nc_index];
    assign nc_wsel = nc_sel.addr[WSEL_W-1:0];

    // Word goes in its own lane, the other lane stays disabled
    always_comb begin
        nc_mem_req.rw     = nc_sel.rw;
        nc_mem_req.addr   = nc_sel.addr[`CORE_ADDR_W-1:WSEL_W];
        nc_mem_req.byteen = '0;
        nc_mem_req.byteen[nc_wsel*`WORD_BYTES +: `WORD_BYTES] = nc_sel.byteen;
        nc_mem_req.data        = {`LINE_WORDS{nc_sel.data}};
        nc_mem_req.tag.nc      = 1'b1;
        nc_mem_req.tag.payload = {nc_index, nc_wsel, nc_sel.tag.id};
    end

    assign mem_req_valid       = cache_mem_req_valid || nc_grant;
    assign mem_req             = nc_drive ? nc_mem_req : cache_mem_req;
    assign cache_mem_req_ready = mem_req_ready && !nc_hold;

    // Response steering
    assign rsp_nc                       = mem_rsp.tag.nc;
    assign {rsp_port, rsp_wsel, rsp_id} = mem_rsp.tag.payload;
    assign rsp_word                     = mem_rsp.data[rsp_wsel*`WORD_W +: `WORD_W];

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            core_rsp_valid_out[i] = cache_rsp_valid[i]
                                 || (mem_rsp_valid && rsp_nc && rsp_port == SEL_W'(i));
            if (cache_rsp_valid[i]) begin
                core_rsp_out[i] = cache_rsp[i];
            end else begin
                core_rsp_out[i].data   = rsp_word;
                core_rsp_out[i].tag.nc = 1'b1;
                core_rsp_out[i].tag.id = rsp_id;
            end
        end
    end

    assign cache_rsp_ready = core_rsp_ready_out;

    assign cache_mem_rsp       = mem_rsp;
    assign cache_mem_rsp_valid = mem_rsp_valid && !rsp_nc;

    // Bypass data waits while the cache owns that port's response
    assign mem_rsp_ready = rsp_nc ? (!cache_rsp_valid[rsp_port] && core_rsp_ready_out[rsp_port])
                                  : cache_mem_rsp_ready;

endmodule

//--- design/line_cache.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module line_cache (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  nc_bypass_pkg::core_req_t [`NUM_PORTS-1:0] core_req,
    input  logic [`NUM_PORTS-1:0]                     core_req_valid,
    output logic [`NUM_PORTS-1:0]                     core_req_ready,
    output nc_bypass_pkg::core_rsp_t [`NUM_PORTS-1:0] core_rsp,
    output logic [`NUM_PORTS-1:0]                     core_rsp_valid,
    input  logic [`NUM_PORTS-1:0]                     core_rsp_ready,
    output nc_bypass_pkg::mem_req_t                   mem_req,
    output logic                                      mem_req_valid,
    input  logic                                      mem_req_ready,
    input  nc_bypass_pkg::mem_rsp_t                   mem_rsp,
    input  logic                                      mem_rsp_valid,
    output logic                                      mem_rsp_ready
);
    import nc_bypass_pkg::*;

    localparam int SEL_W  = `PORT_SEL_W;
    localparam int WSEL_W = `WSEL_W;
    localparam int IDX_W  = `LINE_IDX_W;
    localparam int TAG_W  = `CORE_ADDR_W - WSEL_W - IDX_W;

    logic [TAG_W-1:0]        tag_arr [`CACHE_LINES];
    logic [`LINE_W-1:0]      data_arr [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_arr;

    cache_state_e            state;
    logic [`NUM_PORTS-1:0]   grant_onehot;
    logic [SEL_W-1:0]        grant_index;
    logic                    grant_valid;
    core_req_t               sel;
    logic [TAG_W-1:0]        sel_tag;
    logic [IDX_W-1:0]        sel_idx;
    logic [WSEL_W-1:0]       sel_wsel;
    logic                    hit;
    logic                    read_hit;
    logic                    accept;
    logic                    fill;
    logic [IDX_W-1:0]        fill_idx;
    logic [`CORE_ADDR_W-1:0] pend_addr;
    logic [SEL_W-1:0]        pend_port;
    logic [`ID_W-1:0]        pend_id;
    logic [`WORD_W-1:0]      rsp_data;

    req_arbiter port_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .requests     (core_req_valid),
        .grant_onehot (grant_onehot),
        .grant_index  (grant_index),
        .grant_valid  (grant_valid),
        .unlock       (accept)
    );

    assign sel                         = core_req[grant_index];
    assign {sel_tag, sel_idx, sel_wsel} = sel.addr;
    assign hit      = valid_arr[sel_idx] && (tag_arr[sel_idx] == sel_tag);
    assign read_hit = !sel.rw && hit;

    // Writes and read misses both need the memory port in the same cycle
    assign mem_req_valid  = grant_valid && (state == IDLE) && !read_hit;
    assign accept         = grant_valid && (state == IDLE) && (read_hit || mem_req_ready);
    assign core_req_ready = grant_onehot & {`NUM_PORTS{accept}};

    always_comb begin
        mem_req.rw     = sel.rw;
        mem_req.addr   = sel.addr[`CORE_ADDR_W-1:WSEL_W];
        mem_req.byteen = '1;
        if (sel.rw) begin
            mem_req.byteen = '0;
            mem_req.byteen[sel_wsel*`WORD_BYTES +: `WORD_BYTES] = sel.byteen;
        end
        mem_req.data        = {`LINE_WORDS{sel.data}};
        mem_req.tag.nc      = 1'b0;
        mem_req.tag.payload = `MEM_TAG_W'(sel_idx);
    end

    assign mem_rsp_ready = (state == MISS_WAIT);
    assign fill          = mem_rsp_valid && mem_rsp_ready;
    assign fill_idx      = mem_rsp.tag.payload[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            valid_arr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept && !sel.rw) begin
                        state <= hit ? RESPOND : MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (fill) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (core_rsp_ready[pend_port]) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (fill) begin
                valid_arr[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pend_addr <= sel.addr;
            pend_port <= grant_index;
            pend_id   <= sel.tag.id;
        end
        if (accept && read_hit) begin
            rsp_data <= data_arr[sel_idx][sel_wsel*`WORD_W +: `WORD_W];
        end
        // Write hit updates the stored copy alongside write-through
        if (accept && sel.rw && hit) begin
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (mem_req.byteen[b]) begin
                    data_arr[sel_idx][b*8 +: 8] <= mem_req.data[b*8 +: 8];
                end
            end
        end
        if (fill) begin
            data_arr[fill_idx] <= mem_rsp.data;
            tag_arr[fill_idx]  <= pend_addr[`CORE_ADDR_W-1 -: TAG_W];
            rsp_data           <= mem_rsp.data[pend_addr[WSEL_W-1:0]*`WORD_W +: `WORD_W];
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            core_rsp[i].data   = rsp_data;
            core_rsp[i].tag.nc = 1'b0;
            core_rsp[i].tag.id = pend_id;
            core_rsp_valid[i]  = (state == RESPOND) && (pend_port == SEL_W'(i));
        end
    end

endmodule

//--- design/nc_mem_top.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module nc_mem_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  nc_bypass_pkg::core_req_t [`NUM_PORTS-1:0] core_req,
    input  logic [`NUM_PORTS-1:0]                     core_req_valid,
    output logic [`NUM_PORTS-1:0]                     core_req_ready,
    output nc_bypass_pkg::core_rsp_t [`NUM_PORTS-1:0] core_rsp,
    output logic [`NUM_PORTS-1:0]                     core_rsp_valid,
    input  logic [`NUM_PORTS-1:0]                     core_rsp_ready,
    output nc_bypass_pkg::mem_req_t                   mem_req,
    output logic                                      mem_req_valid,
    input  logic                                      mem_req_ready,
    input  nc_bypass_pkg::mem_rsp_t                   mem_rsp,
    input  logic                                      mem_rsp_valid,
    output logic                                      mem_rsp_ready
);
    import nc_bypass_pkg::*;

    core_req_t [`NUM_PORTS-1:0] cache_req;
    logic [`NUM_PORTS-1:0]      cache_req_valid;
    logic [`NUM_PORTS-1:0]      cache_req_ready;
    core_rsp_t [`NUM_PORTS-1:0] cache_rsp;
    logic [`NUM_PORTS-1:0]      cache_rsp_valid;
    logic [`NUM_PORTS-1:0]      cache_rsp_ready;
    mem_req_t                   cache_mem_req;
    logic                       cache_mem_req_valid;
    logic                       cache_mem_req_ready;
    mem_rsp_t                   cache_mem_rsp;
    logic                       cache_mem_rsp_valid;
    logic                       cache_mem_rsp_ready;

    // Cache and memory channels match by name
    cache_bypass bypass (
        .core_req_in        (core_req),
        .core_req_valid_in  (core_req_valid),
        .core_req_ready_in  (core_req_ready),
        .core_rsp_out       (core_rsp),
        .core_rsp_valid_out (core_rsp_valid),
        .core_rsp_ready_out (core_rsp_ready),
        .*
    );

    line_cache cache (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req       (cache_req),
        .core_req_valid (cache_req_valid),
        .core_req_ready (cache_req_ready),
        .core_rsp       (cache_rsp),
        .core_rsp_valid (cache_rsp_valid),
        .core_rsp_ready (cache_rsp_ready),
        .mem_req        (cache_mem_req),
        .mem_req_valid  (cache_mem_req_valid),
        .mem_req_ready  (cache_mem_req_ready),
        .mem_rsp        (cache_mem_rsp),
        .mem_rsp_valid  (cache_mem_rsp_valid),
        .mem_rsp_ready  (cache_mem_rsp_ready)
    );

endmodule

//--- verification/nc_mem_props.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module nc_mem_props (
    input logic                    clk,
    input logic                    rst_n,
    input nc_bypass_pkg::mem_req_t mem_req,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input logic [`NUM_PORTS-1:0]   core_rsp_valid
);
    // Nothing leaves the top right after a reset cycle
    mem_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !mem_req_valid)
        else $error("mem_req_valid high after reset");

    rsp_valid_after_reset: assert property (@(posedge clk) !rst_n |=> core_rsp_valid == '0)
        else $error("core_rsp_valid high after reset");

    // Stalled memory request holds its payload
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while stalled");

endmodule

bind nc_mem_top nc_mem_props props (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .core_rsp_valid (core_rsp_valid)
);

//--- verification/nc_mem_tb.sv
`timescale 1ns/1ps
`include "nc_bypass_settings.svh"

module nc_mem_tb;
    import nc_bypass_pkg::*;

    localparam int NUM_REQ = 200;
    localparam int MAX_CYC = NUM_REQ * 12;
    localparam int WORDS   = 1 << `CORE_ADDR_W;
    localparam int NUM_IDS = 1 << `ID_W;

    logic                       clk;
    logic                       rst_n;
    core_req_t [`NUM_PORTS-1:0] core_req;
    logic [`NUM_PORTS-1:0]      core_req_valid;
    logic [`NUM_PORTS-1:0]      core_req_ready;
    core_rsp_t [`NUM_PORTS-1:0] core_rsp;
    logic [`NUM_PORTS-1:0]      core_rsp_valid;
    logic [`NUM_PORTS-1:0]      core_rsp_ready;
    mem_req_t                   mem_req;
    logic                       mem_req_valid;
    logic                       mem_req_ready;
    mem_rsp_t                   mem_rsp;
    logic                       mem_rsp_valid;
    logic                       mem_rsp_ready;

    // Memory model, expected contents and one read slot per port and id
    logic [`WORD_W-1:0]         ref_mem [WORDS];
    logic [`WORD_W-1:0]         exp_mem [WORDS];
    logic [`WORD_W-1:0]         exp_data [`NUM_PORTS][NUM_IDS];
    logic                       exp_nc [`NUM_PORTS][NUM_IDS];
    logic                       pending [`NUM_PORTS][NUM_IDS];
    // Expected cache contents, line index is addr[3:1] and tag is addr[9:4]
    logic                       line_valid [`CACHE_LINES];
    logic [5:0]                 line_tag [`CACHE_LINES];
    mem_rsp_t                   rsp_q [$];
    int                         due_q [$];
    core_req_t [`NUM_PORTS-1:0] nxt_req;
    logic [`NUM_PORTS-1:0]      nxt_valid;
    logic [`NUM_PORTS-1:0]      nxt_rsp_ready;
    logic                       nxt_mem_ready;
    logic                       nxt_mem_rsp_valid;
    mem_rsp_t                   nxt_mem_rsp;
    logic [31:0]                rng_state = 32'd41;
    logic                       mem_fire;
    logic                       claimed;
    int                         cycle;
    int                         generated;
    int                         outstanding;
    int                         last_due;
    bit                         done;

    nc_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_mem_req(input int p, input core_req_t r);
        logic [`LINE_BYTES-1:0] be;
        logic [`MEM_TAG_W-1:0]  pl;
        logic [`WORD_W-1:0]     lane;
        be = r.addr[0] ? {r.byteen, 4'h0} : {4'h0, r.byteen};
        // Line fill reads the whole line
        if (!r.rw && !r.tag.nc) begin
            be = 8'hff;
        end
        pl   = r.tag.nc ? {1'(p), r.addr[0], r.tag.id} : {3'b000, r.addr[3:1]};
        lane = r.addr[0] ? mem_req.data[63:32] : mem_req.data[31:0];
        check_value("mem_req.rw", 64'(mem_req.rw), 64'(r.rw));
        check_value("mem_req.addr", 64'(mem_req.addr), 64'(r.addr[9:1]));
        check_value("mem_req.byteen", 64'(mem_req.byteen), 64'(be));
        check_value("mem_req.tag.payload", 64'(mem_req.tag.payload), 64'(pl));
        if (r.rw) begin
            check_value("mem_req.data", 64'(lane), 64'(r.data));
        end
    endtask

    task automatic memory_access();
        mem_rsp_t rsp;
        int       due;
        if (mem_req.rw) begin
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (mem_req.byteen[b]) begin
                    ref_mem[{mem_req.addr, 1'(b / 4)}][(b % 4) * 8 +: 8] =
                        mem_req.data[b * 8 +: 8];
                end
            end
        end else begin
            rsp.data = {ref_mem[{mem_req.addr, 1'b1}], ref_mem[{mem_req.addr, 1'b0}]};
            rsp.tag  = mem_req.tag;
            due      = cycle + 1 + int'(next_rand() % 32'd4);
            // Responses leave in request order
            if (due > last_due) begin
                last_due = due;
            end
            rsp_q.push_back(rsp);
            due_q.push_back(last_due);
        end
    endtask

    task automatic accept_request(input int p);
        core_req_t r;
        logic      miss;
        r    = core_req[p];
        miss = 1'b0;
        if (r.rw) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (r.byteen[b]) begin
                    exp_mem[r.addr][b * 8 +: 8] = r.data[b * 8 +: 8];
                end
            end
        end else begin
            exp_data[p][r.tag.id] = exp_mem[r.addr];
            exp_nc[p][r.tag.id]   = r.tag.nc;
            pending[p][r.tag.id]  = 1'b1;
            outstanding++;
        end
        // Read allocate only
        if (!r.rw && !r.tag.nc) begin
            miss = !line_valid[r.addr[3:1]] || line_tag[r.addr[3:1]] != r.addr[9:4];
            line_valid[r.addr[3:1]] = 1'b1;
            line_tag[r.addr[3:1]]   = r.addr[9:4];
        end
        // Writes and bypass traffic hit memory in the accept cycle, cached reads only on a miss
        if (r.rw || r.tag.nc || miss) begin
            check_value("mem_req_valid & mem_req_ready", 64'(mem_fire), 64'd1);
            check_value("mem_req.tag.nc", 64'(mem_req.tag.nc), 64'(r.tag.nc));
            check_mem_req(p, r);
            claimed = 1'b1;
        end
    endtask

    task automatic check_response(input int p);
        logic [`ID_W-1:0] id;
        id = core_rsp[p].tag.id;
        check_value($sformatf("pending read port %0d", p), 64'(pending[p][id]), 64'd1);
        check_value($sformatf("core_rsp[%0d].data", p), 64'(core_rsp[p].data),
                    64'(exp_data[p][id]));
        check_value($sformatf("core_rsp[%0d].tag.nc", p), 64'(core_rsp[p].tag.nc),
                    64'(exp_nc[p][id]));
        pending[p][id] = 1'b0;
        outstanding--;
    endtask

    task automatic observe_cycle();
        cycle++;
        if (cycle > MAX_CYC) begin
            $display("Timeout: requests still open after %0d cycles", MAX_CYC);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (core_rsp_valid[p] && core_rsp_ready[p]) begin
                check_response(p);
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            void'(rsp_q.pop_front());
            void'(due_q.pop_front());
        end
        mem_fire = mem_req_valid && mem_req_ready;
        claimed  = 1'b0;
        if (mem_fire) begin
            memory_access();
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (core_req_valid[p] && core_req_ready[p]) begin
                accept_request(p);
            end
        end
        check_value("mem_req with matching core request", 64'(claimed), 64'(mem_fire));
    endtask

    task automatic choose_inputs();
        core_req_t   q;
        logic [31:0] r;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (!core_req_valid[p] || core_req_ready[p]) begin
                nxt_valid[p] = 1'b0;
                r = next_rand();
                if (generated < NUM_REQ && r[1:0] != 2'b00) begin
                    // Address bit 9 marks the bypass region
                    q.rw     = r[2];
                    q.addr   = {r[3], 3'b000, r[9:4]};
                    q.byteen = r[2] ? r[17:14] : 4'hf;
                    q.data   = next_rand();
                    q.tag.nc = r[3];
                    q.tag.id = r[13:10];
                    if (q.rw || !pending[p][q.tag.id]) begin
                        nxt_req[p]   = q;
                        nxt_valid[p] = 1'b1;
                        generated++;
                    end
                end
            end
        end
        r = next_rand();
        nxt_mem_ready = |r[1:0];
        for (int p = 0; p < `NUM_PORTS; p++) begin
            nxt_rsp_ready[p] = |r[2 * p + 2 +: 2];
        end
        nxt_mem_rsp_valid = 1'b0;
        if (rsp_q.size() > 0) begin
            nxt_mem_rsp       = rsp_q[0];
            nxt_mem_rsp_valid = due_q[0] <= cycle;
        end
        done = generated == NUM_REQ && nxt_valid == '0 && outstanding == 0
            && rsp_q.size() == 0;
    endtask

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = 32'h5a00_0000 ^ (32'(i) << 12) ^ 32'(i);
            exp_mem[i] = ref_mem[i];
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                pending[p][i] = 1'b0;
            end
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            line_valid[i] = 1'b0;
            line_tag[i]   = '0;
        end
        nxt_req        = '0;
        nxt_valid      = '0;
        nxt_mem_rsp    = '0;
        rst_n          <= 1'b0;
        core_req       <= '0;
        core_req_valid <= '0;
        core_rsp_ready <= '0;
        mem_req_ready  <= 1'b0;
        mem_rsp        <= '0;
        mem_rsp_valid  <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (!done) begin
            @(negedge clk);
            observe_cycle();
            choose_inputs();
            @(posedge clk);
            core_req       <= nxt_req;
            core_req_valid <= nxt_valid;
            core_rsp_ready <= nxt_rsp_ready;
            mem_req_ready  <= nxt_mem_ready;
            mem_rsp        <= nxt_mem_rsp;
            mem_rsp_valid  <= nxt_mem_rsp_valid;
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
design/nc_bypass_pkg.sv
design/req_arbiter.sv
design/cache_bypass.sv
design/line_cache.sv
design/nc_mem_top.sv
verification/nc_mem_props.sv
verification/nc_mem_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module nc_mem_tb -o nc_mem_sim &&
./obj_dir/nc_mem_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" ||
{ echo "Simulation did not pass"; exit 1; }
